// ==== include/bootrom_code.svh ====
// Boot code word list as macros; include in the ROM body and in the bench reference model
`ifndef BOOTROM_CODE_SVH
`define BOOTROM_CODE_SVH

// Words in use, all later entries of the 16 word window read zero
`define BOOTROM_LEN 10

// Stack setup, zero a few registers, then jump to RAM base
`define BOOTROM_WORDS '{ \
   32'h18000000, 32'h18200000, 32'ha8210ffc, 32'h18400000, \
   32'h18600000, 32'h18800000, 32'h18a00000, 32'h44002800, \
   32'h15000000, 32'h00000000 }

`endif

// ==== rtl/tile_pkg.sv ====
// Shared bus widths, region codes, adapter registers and flit encodings; imported by RTL and bench
package tile_pkg;

   localparam int ADDR_W      = 32;          // Bus address
   localparam int DATA_W      = 32;          // Bus and flit data
   localparam int SEL_W       = DATA_W / 8;  // One select per byte
   localparam int FLIT_TYPE_W = 2;

   // High bit marks the first flit of a packet, low bit the last one
   localparam logic [FLIT_TYPE_W-1:0] FLIT_PAYLOAD = 2'b00;
   localparam logic [FLIT_TYPE_W-1:0] FLIT_LAST    = 2'b01;
   localparam logic [FLIT_TYPE_W-1:0] FLIT_HEADER  = 2'b10;
   localparam logic [FLIT_TYPE_W-1:0] FLIT_SINGLE  = 2'b11;

   localparam int         REGION_RAM_BIT = 31;     // Clear means RAM
   localparam logic [3:0] REGION_NA      = 4'he;   // Top nibble of adapter space
   localparam logic [3:0] REGION_ROM     = 4'hf;   // Top nibble of boot ROM space

   localparam logic [3:0] NA_REG_SEND_SIZE = 4'h0;  // Write size, read rx fill
   localparam logic [3:0] NA_REG_DATA      = 4'h4;  // Write send word, read rx word
   localparam logic [3:0] NA_REG_STATUS    = 4'h8;  // Rx not empty, tx full

   localparam int DEST_W  = 5;  // Tile id fields
   localparam int CLASS_W = 3;
   localparam int SRC_W   = 5;
   localparam int USER_W  = DATA_W - DEST_W - CLASS_W - SRC_W;  // 19 bits left over

   // One flit word, seen as payload or as packet header
   typedef union packed {
      logic [DATA_W-1:0] word;        // Plain payload
      struct packed {
         logic [DEST_W-1:0]  dest;    // Target tile
         logic [CLASS_W-1:0] cls;     // Packet class
         logic [SRC_W-1:0]   src;     // Sending tile
         logic [USER_W-1:0]  user;    // Free for software
      } hdr;
   } flit_data_u;

endpackage

// ==== rtl/noc_buffer.sv ====
// Circular flit FIFO with valid/ready on both sides; adapter send and receive queues
`timescale 1ns/1ps

module noc_buffer import tile_pkg::*; #(
   parameter int BUF_DEPTH = 8
) (
   input  logic                           clk,
   input  logic                           arst_n_i,
   input  logic [FLIT_TYPE_W-1:0]         in_type_i,
   input  flit_data_u                     in_data_i,
   input  logic                           in_valid_i,
   output logic                           in_ready_o,
   output logic [FLIT_TYPE_W-1:0]         out_type_o,
   output flit_data_u                     out_data_o,
   output logic                           out_valid_o,
   input  logic                           out_ready_i,
   output logic [$clog2(BUF_DEPTH+1)-1:0] fill_o       // Flits held
);

   localparam int PTR_W  = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int FILL_W = $clog2(BUF_DEPTH + 1);

   logic [FLIT_TYPE_W-1:0] type_mem [BUF_DEPTH];
   flit_data_u             data_mem [BUF_DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic                   push;
   logic                   pop;

   assign in_ready_o  = (fill_o != FILL_W'(BUF_DEPTH));
   assign out_valid_o = (fill_o != '0);
   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;
   assign out_type_o  = type_mem[rd_ptr];  // Head visible the cycle after the write
   assign out_data_o  = data_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         type_mem[wr_ptr] <= in_type_i;
         data_mem[wr_ptr] <= in_data_i;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill_o <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         fill_o <= fill_o + FILL_W'(push) - FILL_W'(pop);
      end
   end

endmodule

// ==== rtl/wb_bus.sv ====
// Tile system bus; round-robin grant over two masters, decode to RAM, adapter and ROM
`timescale 1ns/1ps

module wb_bus import tile_pkg::*; (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic [ADDR_W-1:0] m0_adr_i,
   input  logic [DATA_W-1:0] m0_dat_i,
   input  logic [SEL_W-1:0]  m0_sel_i,
   input  logic              m0_we_i,
   input  logic              m0_cyc_i,
   input  logic              m0_stb_i,
   output logic              m0_ack_o,
   output logic              m0_err_o,
   output logic [DATA_W-1:0] m0_dat_o,
   input  logic [ADDR_W-1:0] m1_adr_i,
   input  logic [DATA_W-1:0] m1_dat_i,
   input  logic [SEL_W-1:0]  m1_sel_i,
   input  logic              m1_we_i,
   input  logic              m1_cyc_i,
   input  logic              m1_stb_i,
   output logic              m1_ack_o,
   output logic              m1_err_o,
   output logic [DATA_W-1:0] m1_dat_o,
   output logic [ADDR_W-1:0] s_ram_adr_o,
   output logic [DATA_W-1:0] s_ram_dat_o,
   output logic [SEL_W-1:0]  s_ram_sel_o,
   output logic              s_ram_we_o,
   output logic              s_ram_stb_o,
   input  logic              s_ram_ack_i,
   input  logic [DATA_W-1:0] s_ram_rdat_i,
   output logic [ADDR_W-1:0] s_na_adr_o,
   output logic [DATA_W-1:0] s_na_dat_o,
   output logic [SEL_W-1:0]  s_na_sel_o,
   output logic              s_na_we_o,
   output logic              s_na_stb_o,
   input  logic              s_na_ack_i,
   input  logic [DATA_W-1:0] s_na_rdat_i,
   output logic [ADDR_W-1:0] s_rom_adr_o,
   output logic [DATA_W-1:0] s_rom_dat_o,
   output logic [SEL_W-1:0]  s_rom_sel_o,
   output logic              s_rom_we_o,
   output logic              s_rom_stb_o,
   input  logic              s_rom_ack_i,
   input  logic [DATA_W-1:0] s_rom_rdat_i
);

   logic              grant;     // 0 is m0, 1 is m1
   logic [ADDR_W-1:0] adr;       // Granted request
   logic [DATA_W-1:0] wdat;
   logic [SEL_W-1:0]  sel;
   logic              we;
   logic              cyc;
   logic              stb;
   logic              hit_ram;
   logic              hit_na;
   logic              hit_rom;
   logic              hit_none;  // Top nibble 8 to D
   logic              ack;
   logic [DATA_W-1:0] rdat;
   logic              err_q;     // Bus-generated error

   assign adr  = grant ? m1_adr_i : m0_adr_i;
   assign wdat = grant ? m1_dat_i : m0_dat_i;
   assign sel  = grant ? m1_sel_i : m0_sel_i;
   assign we   = grant ? m1_we_i  : m0_we_i;
   assign cyc  = grant ? m1_cyc_i : m0_cyc_i;
   assign stb  = cyc & (grant ? m1_stb_i : m0_stb_i);

   assign hit_ram  = ~adr[REGION_RAM_BIT];
   assign hit_na   = (adr[ADDR_W-1 -: 4] == REGION_NA);
   assign hit_rom  = (adr[ADDR_W-1 -: 4] == REGION_ROM);
   assign hit_none = ~(hit_ram | hit_na | hit_rom);

   // Request fans out to all slaves, only stb is decoded
   assign s_ram_adr_o = adr;
   assign s_ram_dat_o = wdat;
   assign s_ram_sel_o = sel;
   assign s_ram_we_o  = we;
   assign s_ram_stb_o = stb & hit_ram;
   assign s_na_adr_o  = adr;
   assign s_na_dat_o  = wdat;
   assign s_na_sel_o  = sel;
   assign s_na_we_o   = we;
   assign s_na_stb_o  = stb & hit_na;
   assign s_rom_adr_o = adr;
   assign s_rom_dat_o = wdat;
   assign s_rom_sel_o = sel;
   assign s_rom_we_o  = we;
   assign s_rom_stb_o = stb & hit_rom;

   assign ack  = (hit_ram & s_ram_ack_i) | (hit_na & s_na_ack_i) | (hit_rom & s_rom_ack_i);
   assign rdat = hit_ram ? s_ram_rdat_i :
                 hit_na  ? s_na_rdat_i  :
                 hit_rom ? s_rom_rdat_i : '0;

   // Answer goes to the granted master only
   assign m0_ack_o = ~grant & ack;
   assign m0_err_o = ~grant & err_q;
   assign m0_dat_o = grant ? '0 : rdat;
   assign m1_ack_o = grant & ack;
   assign m1_err_o = grant & err_q;
   assign m1_dat_o = grant ? rdat : '0;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         grant <= 1'b0;  // Rests on m0
         err_q <= 1'b0;
      end else begin
         if (!cyc && (grant ? m0_cyc_i : m1_cyc_i)) begin
            grant <= ~grant;  // Hand over only between cycles
         end
         err_q <= stb & hit_none & ~err_q;  // One pulse per strobe
      end
   end

endmodule

// ==== rtl/wb_sram_sp.sv ====
// Single-port word RAM on the tile bus; byte selects, aliasing above MEM_SIZE
`timescale 1ns/1ps

module wb_sram_sp import tile_pkg::*; #(
   parameter int MEM_SIZE = 4096  // Bytes, power of two
) (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic [ADDR_W-1:0] adr_i,
   input  logic [DATA_W-1:0] dat_i,
   input  logic [SEL_W-1:0]  sel_i,
   input  logic              we_i,
   input  logic              stb_i,
   output logic              ack_o,
   output logic [DATA_W-1:0] dat_o
);

   localparam int WORDS = MEM_SIZE / 4;
   localparam int IDX_W = $clog2(WORDS);

   logic [DATA_W-1:0] mem [WORDS];
   logic [IDX_W-1:0]  idx;    // Word index, upper bits dropped
   logic              stb_q;
   logic              start;  // First cycle of a strobe

   assign idx   = adr_i[IDX_W+1:2];
   assign start = stb_i & ~stb_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_o <= start;  // Once per strobe
         stb_q <= stb_i;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         if (we_i) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (sel_i[b]) begin
                  mem[idx][8*b +: 8] <= dat_i[8*b +: 8];  // Selected bytes only
               end
            end
         end
         dat_o <= mem[idx];  // Old word on a write, nobody reads it
      end
   end

endmodule

// ==== rtl/bootrom.sv ====
// Boot ROM on the tile bus; 16 word window over the included code list
`timescale 1ns/1ps

`include "bootrom_code.svh"

module bootrom import tile_pkg::*; (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic [ADDR_W-1:0] adr_i,
   input  logic              stb_i,
   output logic              ack_o,
   output logic [DATA_W-1:0] dat_o
);

   localparam logic [DATA_W-1:0] CODE [`BOOTROM_LEN] = `BOOTROM_WORDS;

   logic [3:0] idx;    // Word in window, address wraps every 64 bytes
   logic       stb_q;

   assign idx = adr_i[5:2];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_o <= stb_i & ~stb_q;  // Writes get acked too, then ignored
         stb_q <= stb_i;
      end
   end

   always_ff @(posedge clk) begin
      if (stb_i && !stb_q) begin
         dat_o <= (idx < `BOOTROM_LEN) ? CODE[idx] : '0;  // Past list reads zero
      end
   end

endmodule

// ==== rtl/na_mpsimple.sv ====
// Message-passing network adapter; bus registers, send framing, receive filter and IRQ
`timescale 1ns/1ps

module na_mpsimple import tile_pkg::*; #(
   parameter int TILE_ID   = 3,
   parameter int BUF_DEPTH = 8
) (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic [ADDR_W-1:0]      adr_i,
   input  logic [DATA_W-1:0]      dat_i,
   input  logic                   we_i,
   input  logic                   stb_i,
   output logic                   ack_o,
   output logic [DATA_W-1:0]      dat_o,
   input  logic [FLIT_TYPE_W-1:0] noc_in_type_i,
   input  flit_data_u             noc_in_data_i,
   input  logic                   noc_in_valid_i,
   output logic                   noc_in_ready_o,
   output logic [FLIT_TYPE_W-1:0] noc_out_type_o,
   output flit_data_u             noc_out_data_o,
   output logic                   noc_out_valid_o,
   input  logic                   noc_out_ready_i,
   output logic                   irq_o
);

   logic [3:0]                     reg_ofs;      // Byte offset in register block
   logic                           is_data;
   logic                           done;         // Strobe already acked
   logic                           stall;        // Send FIFO full on data write
   logic                           ack_fire;
   logic [DATA_W-1:0]              remain;       // Words left in packet
   logic                           in_pkt;
   logic                           first;
   logic                           last;
   logic                           tx_in_valid;
   logic                           tx_in_ready;
   logic [FLIT_TYPE_W-1:0]         tx_type;
   flit_data_u                     tx_data;
   logic                           cur_drop;     // Current rx flit is discarded
   logic                           drop_q;       // Inside a foreign packet
   logic                           rx_in_valid;
   logic                           rx_in_ready;
   flit_data_u                     rx_out_data;
   logic                           rx_out_valid;
   logic                           rx_out_ready;
   logic [$clog2(BUF_DEPTH+1)-1:0] rx_fill;

   assign reg_ofs  = {adr_i[3:2], 2'b00};
   assign is_data  = (reg_ofs == NA_REG_DATA);
   assign in_pkt   = (remain != '0);
   assign last     = (remain == DATA_W'(1));
   assign stall    = we_i & is_data & in_pkt & ~tx_in_ready;
   assign ack_fire = stb_i & ~done & ~stall;

   // Send side, words outside a packet are acked and dropped
   assign tx_in_valid = ack_fire & we_i & is_data & in_pkt;
   assign tx_type     = first ? (last ? FLIT_SINGLE : FLIT_HEADER) :
                                (last ? FLIT_LAST   : FLIT_PAYLOAD);

   always_comb begin
      tx_data.word = dat_i;
      if (first) begin
         tx_data.hdr.src = SRC_W'(TILE_ID);  // Stamp own tile as source
      end
   end

   // Receive side, header bit decides keep or drop for the whole packet
   assign cur_drop       = noc_in_type_i[1] ? (noc_in_data_i.hdr.dest != DEST_W'(TILE_ID))
                                            : drop_q;
   assign rx_in_valid    = noc_in_valid_i & ~cur_drop;
   assign noc_in_ready_o = cur_drop | rx_in_ready;
   assign rx_out_ready   = ack_fire & ~we_i & is_data;  // Read pops
   assign irq_o          = rx_out_valid;

   noc_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_tx_buf (
      .clk, .arst_n_i,
      .in_type_i   (tx_type),         .in_data_i   (tx_data),
      .in_valid_i  (tx_in_valid),     .in_ready_o  (tx_in_ready),
      .out_type_o  (noc_out_type_o),  .out_data_o  (noc_out_data_o),
      .out_valid_o (noc_out_valid_o), .out_ready_i (noc_out_ready_i),
      .fill_o      ()
   );

   noc_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_rx_buf (
      .clk, .arst_n_i,
      .in_type_i   (noc_in_type_i),   .in_data_i   (noc_in_data_i),
      .in_valid_i  (rx_in_valid),     .in_ready_o  (rx_in_ready),
      .out_type_o  (),                .out_data_o  (rx_out_data),     // Software reads words
      .out_valid_o (rx_out_valid),    .out_ready_i (rx_out_ready),
      .fill_o      (rx_fill)
   );

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o  <= 1'b0;
         done   <= 1'b0;
         remain <= '0;
         first  <= 1'b0;
         drop_q <= 1'b0;
      end else begin
         ack_o <= ack_fire;
         done  <= stb_i & (done | ack_fire);  // Cleared once stb drops
         if (ack_fire && we_i && reg_ofs == NA_REG_SEND_SIZE) begin
            remain <= dat_i;  // New packet
            first  <= 1'b1;
         end else if (tx_in_valid) begin
            remain <= remain - 1'b1;
            first  <= 1'b0;
         end
         if (noc_in_valid_i && noc_in_ready_o) begin
            drop_q <= cur_drop & ~noc_in_type_i[0];  // Ends with the last flit
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ack_fire && !we_i) begin
         case (reg_ofs)
            NA_REG_SEND_SIZE: dat_o <= DATA_W'(rx_fill);
            NA_REG_DATA:      dat_o <= rx_out_valid ? rx_out_data.word : '0;
            NA_REG_STATUS:    dat_o <= {{(DATA_W-2){1'b0}}, ~tx_in_ready, rx_out_valid};
            default:          dat_o <= '0;
         endcase
      end
   end

endmodule

// ==== rtl/compute_tile_dm.sv ====
// Compute tile top level; two bus masters share RAM, adapter and boot ROM behind one bus
`timescale 1ns/1ps

module compute_tile_dm import tile_pkg::*; #(
   parameter int MEM_SIZE  = 4096,  // RAM bytes, power of two
   parameter int TILE_ID   = 3,
   parameter int BUF_DEPTH = 8      // Flits per adapter FIFO
) (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic [ADDR_W-1:0]      m0_adr_i,  // Instruction side
   input  logic [DATA_W-1:0]      m0_dat_i,
   input  logic [SEL_W-1:0]       m0_sel_i,
   input  logic                   m0_we_i,
   input  logic                   m0_cyc_i,
   input  logic                   m0_stb_i,
   output logic                   m0_ack_o,
   output logic                   m0_err_o,
   output logic [DATA_W-1:0]      m0_dat_o,
   input  logic [ADDR_W-1:0]      m1_adr_i,  // Data side
   input  logic [DATA_W-1:0]      m1_dat_i,
   input  logic [SEL_W-1:0]       m1_sel_i,
   input  logic                   m1_we_i,
   input  logic                   m1_cyc_i,
   input  logic                   m1_stb_i,
   output logic                   m1_ack_o,
   output logic                   m1_err_o,
   output logic [DATA_W-1:0]      m1_dat_o,
   input  logic [FLIT_TYPE_W-1:0] noc_in_type_i,
   input  flit_data_u             noc_in_data_i,
   input  logic                   noc_in_valid_i,
   output logic                   noc_in_ready_o,
   output logic [FLIT_TYPE_W-1:0] noc_out_type_o,
   output flit_data_u             noc_out_data_o,
   output logic                   noc_out_valid_o,
   input  logic                   noc_out_ready_i,
   output logic                   irq_o                 // Rx data waiting
);

   logic [ADDR_W-1:0] ram_adr;  // Shared request lines per slave
   logic [DATA_W-1:0] ram_wdat;
   logic [SEL_W-1:0]  ram_sel;
   logic              ram_we;
   logic              ram_stb;
   logic              ram_ack;
   logic [DATA_W-1:0] ram_rdat;
   logic [ADDR_W-1:0] na_adr;
   logic [DATA_W-1:0] na_wdat;
   logic              na_we;
   logic              na_stb;
   logic              na_ack;
   logic [DATA_W-1:0] na_rdat;
   logic [ADDR_W-1:0] rom_adr;
   logic              rom_stb;
   logic              rom_ack;
   logic [DATA_W-1:0] rom_rdat;

   wb_bus u_bus (
      .clk, .arst_n_i,
      .m0_adr_i, .m0_dat_i, .m0_sel_i, .m0_we_i, .m0_cyc_i, .m0_stb_i,
      .m0_ack_o, .m0_err_o, .m0_dat_o,
      .m1_adr_i, .m1_dat_i, .m1_sel_i, .m1_we_i, .m1_cyc_i, .m1_stb_i,
      .m1_ack_o, .m1_err_o, .m1_dat_o,
      .s_ram_adr_o (ram_adr),  .s_ram_dat_o (ram_wdat), .s_ram_sel_o (ram_sel),
      .s_ram_we_o  (ram_we),   .s_ram_stb_o (ram_stb),
      .s_ram_ack_i (ram_ack),  .s_ram_rdat_i (ram_rdat),
      .s_na_adr_o  (na_adr),   .s_na_dat_o  (na_wdat),  .s_na_sel_o  (),      // Adapter is word wide
      .s_na_we_o   (na_we),    .s_na_stb_o  (na_stb),
      .s_na_ack_i  (na_ack),   .s_na_rdat_i (na_rdat),
      .s_rom_adr_o (rom_adr),  .s_rom_dat_o (),         .s_rom_sel_o (),      // ROM ignores writes
      .s_rom_we_o  (),         .s_rom_stb_o (rom_stb),
      .s_rom_ack_i (rom_ack),  .s_rom_rdat_i (rom_rdat)
   );

   wb_sram_sp #(.MEM_SIZE(MEM_SIZE)) u_ram (
      .clk, .arst_n_i,
      .adr_i (ram_adr), .dat_i (ram_wdat), .sel_i (ram_sel), .we_i (ram_we),
      .stb_i (ram_stb), .ack_o (ram_ack),  .dat_o (ram_rdat)
   );

   na_mpsimple #(.TILE_ID(TILE_ID), .BUF_DEPTH(BUF_DEPTH)) u_na (
      .clk, .arst_n_i,
      .adr_i (na_adr), .dat_i (na_wdat), .we_i (na_we), .stb_i (na_stb),
      .ack_o (na_ack), .dat_o (na_rdat),
      .noc_in_type_i, .noc_in_data_i, .noc_in_valid_i, .noc_in_ready_o,
      .noc_out_type_o, .noc_out_data_o, .noc_out_valid_o, .noc_out_ready_i,
      .irq_o
   );

   bootrom u_bootrom (
      .clk, .arst_n_i,
      .adr_i (rom_adr), .stb_i (rom_stb), .ack_o (rom_ack), .dat_o (rom_rdat)
   );

endmodule

// ==== bench/tb_clkgen.sv ====
// Bench clock and reset source; instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD     = 100,  // ns
   parameter int RST_CYCLES = 3
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o    = 1'b0;
      arst_n_o = 1'b0;  // Held from time zero
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;  // Release away from the rising edge
   end

   always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== bench/tb_compute_tile_dm.sv ====
// Testbench for the compute tile; bus traffic from both masters, NoC send and receive checks
`timescale 1ns/1ps

`include "bootrom_code.svh"

module tb_compute_tile_dm import tile_pkg::*; ();

   localparam int MEM_SIZE = 4096;
   localparam int TILE_ID  = 3;
   localparam int WORDS    = MEM_SIZE / 4;
   localparam int N_RAM    = 16;                        // Addresses per master
   localparam int N_TRANS  = 6 * N_RAM + 18 + 8 + 13 + 20;  // Planned bus and NoC transfers
   localparam int LIMIT    = 50 * N_TRANS;              // Cycles before giving up
   localparam logic [ADDR_W-1:0] NA_BASE  = 32'he000_0000;
   localparam logic [ADDR_W-1:0] ROM_BASE = 32'hf000_0000;
   localparam logic [DATA_W-1:0] ROM_CODE [`BOOTROM_LEN] = `BOOTROM_WORDS;

   logic clk, arst_n;
   logic [ADDR_W-1:0] m0_adr, m1_adr;
   logic [DATA_W-1:0] m0_dat, m1_dat, m0_rdat, m1_rdat;
   logic [SEL_W-1:0]  m0_sel, m1_sel;
   logic m0_we, m0_cyc, m0_stb, m0_ack, m0_err;
   logic m1_we, m1_cyc, m1_stb, m1_ack, m1_err;
   logic [FLIT_TYPE_W-1:0] noc_in_type, noc_out_type;
   flit_data_u noc_in_data, noc_out_data;
   logic noc_in_valid, noc_in_ready, noc_out_valid, noc_out_ready, irq;

   logic [31:0]       lfsr_state = 32'hc61dea65;
   logic [DATA_W-1:0] shadow [WORDS];                   // RAM model
   logic [FLIT_TYPE_W-1:0] exp_type_q [$];              // Flits due on noc_out
   flit_data_u        exp_data_q [$];
   logic              rand_ready = 1'b0;                // Random back-pressure on
   int errors = 0, pass_tests = 0, fail_tests = 0;

   tb_clkgen #(.PERIOD(100), .RST_CYCLES(3)) u_clkgen (.clk_o (clk), .arst_n_o (arst_n));

   compute_tile_dm #(.MEM_SIZE(MEM_SIZE), .TILE_ID(TILE_ID), .BUF_DEPTH(8)) DUT (
      .clk, .arst_n_i (arst_n),
      .m0_adr_i (m0_adr), .m0_dat_i (m0_dat), .m0_sel_i (m0_sel), .m0_we_i (m0_we),
      .m0_cyc_i (m0_cyc), .m0_stb_i (m0_stb), .m0_ack_o (m0_ack), .m0_err_o (m0_err),
      .m0_dat_o (m0_rdat),
      .m1_adr_i (m1_adr), .m1_dat_i (m1_dat), .m1_sel_i (m1_sel), .m1_we_i (m1_we),
      .m1_cyc_i (m1_cyc), .m1_stb_i (m1_stb), .m1_ack_o (m1_ack), .m1_err_o (m1_err),
      .m1_dat_o (m1_rdat),
      .noc_in_type_i (noc_in_type), .noc_in_data_i (noc_in_data),
      .noc_in_valid_i (noc_in_valid), .noc_in_ready_o (noc_in_ready),
      .noc_out_type_o (noc_out_type), .noc_out_data_o (noc_out_data),
      .noc_out_valid_o (noc_out_valid), .noc_out_ready_i (noc_out_ready),
      .irq_o (irq)
   );

   // Galois LFSR, one step per bit handed out
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      end
      return r;
   endfunction

   // Expected read data from the memory map
   function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] adr);
      if (!adr[REGION_RAM_BIT]) return shadow[(adr >> 2) % WORDS];  // Aliases above MEM_SIZE
      if (adr[31:28] == REGION_ROM) begin
         return (adr[5:2] < `BOOTROM_LEN) ? ROM_CODE[adr[5:2]] : '0;
      end
      return '0;  // Unmapped
   endfunction

   // Expected outgoing flit word, source stamped on the header
   function automatic flit_data_u ref_flit(input logic [DATA_W-1:0] w, input logic first);
      flit_data_u d;
      d.word = w;
      if (first) d.hdr.src = SRC_W'(TILE_ID);
      return d;
   endfunction

   task automatic check_word(input logic [DATA_W-1:0] got, exp, input string msg);
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_flit(input logic [FLIT_TYPE_W-1:0] gt, et,
                             input flit_data_u gd, ed);
      if (gt !== et || gd !== ed) begin
         errors++;
         $display("ERR %0t: flit got %b/%h expected %b/%h", $time, gt, gd, et, ed);
      end
   endtask

   task automatic check_err(input logic got, exp, input string msg);
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s err flag %b expected %b", $time, msg, got, exp);
      end
   endtask

   // One bus cycle on master m, returns at the falling edge that saw ack or err
   task automatic bus_access(input int m, input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                             output logic [DATA_W-1:0] rdat, output logic ack, err);
      @(negedge clk);
      if (m == 0) {m0_adr, m0_dat, m0_sel, m0_we, m0_cyc, m0_stb} = {adr, dat, sel, we, 2'b11};
      else        {m1_adr, m1_dat, m1_sel, m1_we, m1_cyc, m1_stb} = {adr, dat, sel, we, 2'b11};
      do @(negedge clk);
      while (m == 0 ? !(m0_ack | m0_err) : !(m1_ack | m1_err));
      rdat = m == 0 ? m0_rdat : m1_rdat;
      ack  = m == 0 ? m0_ack  : m1_ack;
      err  = m == 0 ? m0_err  : m1_err;
      if (m == 0) {m0_cyc, m0_stb} = 2'b00;  // Idle at least one cycle
      else        {m1_cyc, m1_stb} = 2'b00;
   endtask

   task automatic wr(input int m, input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                     input logic [SEL_W-1:0] sel);
      logic [DATA_W-1:0] rd;
      logic ack, err;
      bus_access(m, 1'b1, adr, dat, sel, rd, ack, err);
      check_err(err, 1'b0, "write");
   endtask

   task automatic rd_check(input int m, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] exp, input string msg);
      logic [DATA_W-1:0] rd;
      logic ack, err;
      bus_access(m, 1'b0, adr, '0, '1, rd, ack, err);
      check_err(err, 1'b0, msg);
      check_word(rd, exp, msg);
   endtask

   // Each master owns half the words so the shadow needs no ordering
   task automatic ram_master(input int m);
      logic [ADDR_W-1:0] adr [N_RAM];
      logic [DATA_W-1:0] w;
      logic [SEL_W-1:0]  sel;
      for (int i = 0; i < N_RAM; i++) begin
         adr[i] = {18'b0, 2'(lfsr_bits(2)), m[0], 9'(lfsr_bits(9)), 2'b00};  // Random alias
         w = lfsr_bits(32);
         wr(m, adr[i], w, 4'hf);  // Full word first, RAM starts unknown
         shadow[(adr[i] >> 2) % WORDS] = w;
      end
      for (int i = 0; i < N_RAM; i++) begin
         w   = lfsr_bits(32);
         sel = SEL_W'(lfsr_bits(4));
         wr(m, adr[i] + 32'h1000, w, sel);
         for (int b = 0; b < SEL_W; b++)
            if (sel[b]) shadow[(adr[i] >> 2) % WORDS][8*b +: 8] = w[8*b +: 8];
      end
      for (int i = 0; i < N_RAM; i++) rd_check(m, adr[i] + 32'h3000, ref_read(adr[i]), "ram");
   endtask

   task automatic inject(input logic [FLIT_TYPE_W-1:0] t, input logic [DATA_W-1:0] w);
      @(negedge clk);
      noc_in_type       = t;
      noc_in_data.word  = w;
      noc_in_valid      = 1'b1;
      do @(posedge clk); while (!noc_in_ready);  // Ready stable since the falling edge
      @(negedge clk);
      noc_in_valid = 1'b0;
   endtask

   task automatic end_test(input string name, input int err_before);
      if (errors == err_before) begin
         pass_tests++;
         $display("test %s: ok", name);
      end else begin
         fail_tests++;
         $display("test %s: %0d mismatches", name, errors - err_before);
      end
   endtask

   always @(negedge clk) noc_out_ready <= rand_ready ? 1'(lfsr_bits(1)) : 1'b1;

   // Compare every accepted outgoing flit with the queue
   always @(posedge clk) begin
      if (arst_n && noc_out_valid && noc_out_ready) begin
         if (exp_type_q.size() == 0) begin
            errors++;
            $display("Flit left on noc_out at %0t when none was expected", $time);
         end else begin
            check_flit(noc_out_type, exp_type_q.pop_front(), noc_out_data, exp_data_q.pop_front());
         end
      end
   end

   initial begin
      repeat (LIMIT) @(posedge clk);
      $display("Run stopped after %0d cycles without finishing", LIMIT);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      int e, n;
      logic [DATA_W-1:0] w, rdat;
      logic ack, err;
      logic [DATA_W-1:0] rx_q [$];
      logic [DEST_W-1:0] dests [5] = '{5'd3, 5'd9, 5'd3, 5'd17, 5'd3};
      int lens [5] = '{3, 2, 1, 3, 2};
      {m0_adr, m0_dat, m0_sel, m0_we, m0_cyc, m0_stb} = '0;
      {m1_adr, m1_dat, m1_sel, m1_we, m1_cyc, m1_stb} = '0;
      noc_in_type   = '0;
      noc_in_data   = '0;
      noc_in_valid  = 1'b0;
      noc_out_ready = 1'b1;
      @(posedge arst_n);

      e = errors;
      fork
         ram_master(0);
         ram_master(1);
      join
      end_test("ram", e);

      e = errors;
      for (int i = 0; i < 16; i++) rd_check(0, ROM_BASE + 4 * i, ref_read(ROM_BASE + 4 * i), "rom");
      wr(1, ROM_BASE + 8, 32'hdead_beef, 4'hf);
      rd_check(1, ROM_BASE + 8, ref_read(ROM_BASE + 8), "rom after write");
      end_test("rom", e);

      e = errors;
      for (int t = 8; t <= 13; t++) begin
         bus_access(t % 2, 1'b0, {t[3:0], 28'(lfsr_bits(28))}, '0, '1, rdat, ack, err);
         check_err(err, 1'b1, "unmapped");
         check_word({31'b0, ack}, '0, "ack on unmapped");
      end
      wr(0, 32'h40, 32'h1234_5678, 4'hf);
      shadow[16] = 32'h1234_5678;
      rd_check(1, 32'h40, ref_read(32'h40), "ram after err");
      end_test("unmapped", e);

      e = errors;
      rand_ready = 1'b1;
      foreach (lens[p]) begin
         if (p > 1) break;  // Two outgoing packets, sizes 3 and 2
         wr(1, NA_BASE + NA_REG_SEND_SIZE, lens[p], 4'hf);
         for (int i = 0; i < lens[p]; i++) begin
            w = lfsr_bits(32);
            exp_type_q.push_back({i == 0, i == lens[p] - 1});
            exp_data_q.push_back(ref_flit(w, i == 0));
            wr(1, NA_BASE + NA_REG_DATA, w, 4'hf);
         end
      end
      wr(1, NA_BASE + NA_REG_DATA, 32'hbad0_0bad, 4'hf);  // Outside a packet
      while (exp_type_q.size() != 0) @(negedge clk);
      repeat (20) @(negedge clk);
      check_word({31'b0, noc_out_valid}, '0, "stray flit pending");
      rand_ready = 1'b0;
      end_test("send", e);

      e = errors;
      check_word({31'b0, irq}, '0, "irq before rx");
      foreach (lens[p]) begin
         for (int i = 0; i < lens[p]; i++) begin
            w = lfsr_bits(32);
            if (i == 0) w[31 -: DEST_W] = dests[p];
            if (dests[p] == DEST_W'(TILE_ID)) rx_q.push_back(w);
            inject({i == 0, i == lens[p] - 1}, w);
         end
      end
      @(negedge clk);
      check_word({31'b0, irq}, 32'd1, "irq with data");
      n = rx_q.size();
      rd_check(0, NA_BASE + NA_REG_SEND_SIZE, n, "rx count");
      for (int i = 0; i < n; i++) rd_check(1, NA_BASE + NA_REG_DATA, rx_q[i], "rx word");
      rd_check(1, NA_BASE + NA_REG_DATA, '0, "rx empty read");
      check_word({31'b0, irq}, '0, "irq after drain");
      rd_check(0, NA_BASE + NA_REG_STATUS, '0, "status after drain");
      end_test("receive", e);

      $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
      if (fail_tests == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/tile_pkg.sv
rtl/noc_buffer.sv
rtl/wb_bus.sv
rtl/wb_sram_sp.sv
rtl/bootrom.sv
rtl/na_mpsimple.sv
rtl/compute_tile_dm.sv
bench/tb_clkgen.sv
bench/tb_compute_tile_dm.sv

// ==== Makefile ====
# Verilator build and run of the compute tile testbench

VERILATOR ?= verilator
TOP       ?= tb_compute_tile_dm
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
JOBS      ?= 4

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS JOBS"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
